//--- bench/riscv_id_tb.sv
module riscv_id_tb;
    import riscv_isa_pkg::*;
    import riscv_ctrl_pkg::*;

    localparam int RAND_CYCLES = 2000;
    localparam int MAX_CYCLES  = RAND_CYCLES + 200;   // directed list, reset and margin.
    localparam logic [6:0] LEGAL_OPC [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYSTEM};

    logic       clk;
    logic       rst_n;
    logic       inst_valid;
    inst_t      inst;
    data_t      pc;
    logic       stall;
    logic       flush;
    logic       id_valid;
    id_bundle_t id_out;

    logic       model_valid;
    id_bundle_t model_out;
    logic       seen_valid;
    int         seed = 69449;
    int         cycle_count;
    int         valid_errors;
    int         imm_errors;
    int         ctrl_errors;
    int         reg_errors;

    riscv_id dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .id_valid   (id_valid),
        .id_out     (id_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ====================
    // reference decode
    // ====================
    function automatic id_bundle_t ref_decode(input logic [31:0] w, input data_t pc_in);
        id_bundle_t b;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        alu_op_t    fn;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        b   = '0;
        b.pc            = pc_in;
        b.ctrl.alu_op   = ALU_ADD;
        b.ctrl.op_a_sel = OPA_RS1;
        b.ctrl.op_b_sel = OPB_IMM;
        b.ctrl.mem_size = f3;
        case (f3)
            3'd0: fn = ALU_ADD;
            3'd1: fn = ALU_SLL;
            3'd2: fn = ALU_SLT;
            3'd3: fn = ALU_SLTU;
            3'd4: fn = ALU_XOR;
            3'd5: begin
                if (w[30]) begin
                    fn = ALU_SRA;
                end else begin
                    fn = ALU_SRL;
                end
            end
            3'd6: fn = ALU_OR;
            default: fn = ALU_AND;
        endcase
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                b.imm            = {w[31:12], 12'b0};
                b.ctrl.reg_write = 1'b1;
                if (opc == OPC_LUI) begin
                    b.ctrl.alu_op   = ALU_PASS_B;
                    b.ctrl.op_a_sel = OPA_ZERO;
                end else begin
                    b.ctrl.op_a_sel = OPA_PC;
                end
            end
            OPC_JAL: begin
                b.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                b.ctrl.op_a_sel  = OPA_PC;
                b.ctrl.jump      = 1'b1;
                b.ctrl.reg_write = 1'b1;
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                b.imm            = {{20{w[31]}}, w[31:20]};
                b.ctrl.reg_write = 1'b1;
                b.ctrl.use_rs1   = 1'b1;
                b.ctrl.jump      = (opc == OPC_JALR);
                b.ctrl.mem_read  = (opc == OPC_LOAD);
                if (opc == OPC_OP_IMM) begin
                    b.ctrl.alu_op = fn;
                end
            end
            OPC_BRANCH: begin
                b.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                b.ctrl.alu_op   = ALU_SUB;
                b.ctrl.op_b_sel = OPB_RS2;
                b.ctrl.branch   = 1'b1;
                b.ctrl.use_rs1  = 1'b1;
                b.ctrl.use_rs2  = 1'b1;
            end
            OPC_STORE: begin
                b.imm            = {{20{w[31]}}, w[31:25], w[11:7]};
                b.ctrl.mem_write = 1'b1;
                b.ctrl.use_rs1   = 1'b1;
                b.ctrl.use_rs2   = 1'b1;
            end
            OPC_OP: begin
                b.ctrl.alu_op = fn;
                if (f3 == 3'd0 && w[30]) begin
                    b.ctrl.alu_op = ALU_SUB;
                end
                b.ctrl.op_b_sel  = OPB_RS2;
                b.ctrl.reg_write = 1'b1;
                b.ctrl.use_rs1   = 1'b1;
                b.ctrl.use_rs2   = 1'b1;
                b.ctrl.illegal   = !(f7 == 7'h00 || f7 == 7'h20) ||
                                   (w[30] && f3 != 3'd0 && f3 != 3'd5);
            end
            OPC_FENCE, OPC_SYSTEM: begin
                b.imm = '0;                                 // legal no-ops.
            end
            default: b.ctrl.illegal = 1'b1;
        endcase
        if (b.ctrl.illegal) begin
            b.ctrl.reg_write = 1'b0;
            b.ctrl.mem_read  = 1'b0;
            b.ctrl.mem_write = 1'b0;
            b.ctrl.branch    = 1'b0;
            b.ctrl.jump      = 1'b0;
        end
        b.rs1 = b.ctrl.use_rs1   ? w[19:15] : 5'd0;
        b.rs2 = b.ctrl.use_rs2   ? w[24:20] : 5'd0;
        b.rd  = b.ctrl.reg_write ? w[11:7]  : 5'd0;
        return b;
    endfunction

    // model of the decode register.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_valid <= 1'b0;
            model_out   <= '0;
        end else if (flush) begin
            model_valid <= 1'b0;
        end else if (!stall) begin
            model_valid <= inst_valid;
            if (inst_valid) begin
                model_out <= ref_decode(inst.raw, pc);
            end
        end
    end

    // ====================
    // compare tasks
    // ====================
    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            valid_errors++;
        end
    endtask

    task automatic check_imm(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            imm_errors++;
        end
    endtask

    task automatic check_ctrl(input string name, input id_ctrl_t got, input id_ctrl_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            ctrl_errors++;
        end
    endtask

    task automatic check_regs(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            reg_errors++;
        end
    endtask

    initial begin
        seen_valid = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            check_valid("id_valid", id_valid, model_valid);
            if (model_valid) begin
                seen_valid = 1'b1;
            end
            // before the first instruction the bundle must still be all zeros.
            if (model_valid || !seen_valid) begin
                check_imm("id_out.pc", id_out.pc, model_out.pc);
                check_imm("id_out.imm", id_out.imm, model_out.imm);
                check_ctrl("id_out.ctrl", id_out.ctrl, model_out.ctrl);
                check_regs("id_out.rs1", id_out.rs1, model_out.rs1);
                check_regs("id_out.rs2", id_out.rs2, model_out.rs2);
                check_regs("id_out.rd", id_out.rd, model_out.rd);
            end
        end
    end

    // ====================
    // stimulus
    // ====================
    function automatic logic chance(input int unsigned percent);
        int unsigned r;
        r = $random(seed);
        return (r % 100) < percent;
    endfunction

    task automatic send_word(input logic [31:0] word);
        @(negedge clk);
        inst       = word;
        pc         = pc + 32'd4;
        inst_valid = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
    endtask

    task automatic set_controls(input logic vld, input logic stl, input logic fls);
        @(negedge clk);
        inst_valid = vld;
        stall      = stl;
        flush      = fls;
    endtask

    initial begin
        int unsigned rnd;
        int unsigned pick;
        logic [6:0]  opc;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = 32'h0000_1000;
        stall        = 1'b0;
        flush        = 1'b0;
        valid_errors = 0;
        imm_errors   = 0;
        ctrl_errors  = 0;
        reg_errors   = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);                          // idle, outputs stay zero.

        send_word(32'hfffff2b7);                            // lui, negative.
        send_word(32'h12345097);                            // auipc.
        send_word(32'hff9ff0ef);                            // jal -8.
        send_word(32'h00008067);                            // jalr.
        send_word(32'hfe208ee3);                            // beq -4.
        send_word(32'hffc42383);                            // lw -4.
        send_word(32'h00840383);                            // lb 8.
        send_word(32'hfe952c23);                            // sw -8.
        send_word(32'hfff00093);                            // addi -1.
        send_word(32'h40535293);                            // srai.
        send_word(32'h002081b3);                            // add.
        send_word(32'h402081b3);                            // sub.
        send_word(32'h0062d233);                            // srl.
        send_word(32'h4062d233);                            // sra.
        send_word(32'h0ff0000f);                            // fence.
        send_word(32'h00000073);                            // ecall.
        send_word(32'h0000007f);                            // unknown opcode.
        send_word(32'h022081b3);                            // funct7 0x01 in op.
        send_word(32'h4020c1b3);                            // bit 30 with xor.

        // hold, then flush while stalled.
        send_word(32'h00a50533);
        @(negedge clk);
        inst  = 32'h40a50533;                               // new word as stall rises.
        pc    = pc + 32'd4;
        stall = 1'b1;
        set_controls(1'b1, 1'b1, 1'b0);
        set_controls(1'b1, 1'b0, 1'b0);                     // held word goes through.
        set_controls(1'b1, 1'b1, 1'b1);
        set_controls(1'b0, 1'b0, 1'b0);

        for (int n = 0; n < RAND_CYCLES; n++) begin
            @(negedge clk);
            if (!stall) begin
                rnd  = $random(seed);
                pick = $random(seed);
                if (chance(6)) begin
                    opc = rnd[6:0];
                end else begin
                    opc = LEGAL_OPC[pick % 11];
                end
                inst       = {rnd[31:7], opc};
                pc         = pc + 32'd4;
                inst_valid = chance(80);
            end
            stall = chance(20);
            flush = chance(5);
        end
        set_controls(1'b0, 1'b0, 1'b0);
        repeat (3) @(negedge clk);

        $display("errors: valid %0d, imm %0d, ctrl %0d, regs %0d",
                 valid_errors, imm_errors, ctrl_errors, reg_errors);
        if (valid_errors + imm_errors + ctrl_errors + reg_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: test did not end within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- design/riscv_ctrl_pkg.sv
package riscv_ctrl_pkg;

    // ====================
    // operation encodings
    // ====================
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_PC   = 2'd1,
        OPA_ZERO = 2'd2
    } op_a_sel_t;

    typedef enum logic {
        OPB_RS2 = 1'b0,
        OPB_IMM = 1'b1
    } op_b_sel_t;

    // ====================
    // decode outputs
    // ====================
    typedef struct packed {
        alu_op_t    alu_op;
        op_a_sel_t  op_a_sel;
        op_b_sel_t  op_b_sel;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] mem_size;   // funct3, also the branch condition.
        logic       branch;
        logic       jump;
        logic       reg_write;
        logic       use_rs1;
        logic       use_rs2;
        logic       illegal;
    } id_ctrl_t;

    typedef struct packed {
        riscv_isa_pkg::data_t     pc;
        riscv_isa_pkg::data_t     imm;
        riscv_isa_pkg::reg_addr_t rs1;
        riscv_isa_pkg::reg_addr_t rs2;
        riscv_isa_pkg::reg_addr_t rd;
        id_ctrl_t                 ctrl;
    } id_bundle_t;

endpackage

//--- design/riscv_id.sv
module riscv_id (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       inst_valid,
    input  riscv_isa_pkg::inst_t       inst,
    input  riscv_isa_pkg::data_t       pc,
    input  logic                       stall,
    input  logic                       flush,
    output logic                       id_valid,
    output riscv_ctrl_pkg::id_bundle_t id_out
);
    import riscv_isa_pkg::*;
    import riscv_ctrl_pkg::*;

    data_t    imm;
    id_ctrl_t ctrl;

    riscv_id_imm imm_i (
        .inst (inst),
        .imm  (imm)
    );

    riscv_id_ctrl ctrl_i (
        .inst (inst),
        .ctrl (ctrl)
    );

    riscv_id_reg reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .imm        (imm),
        .ctrl       (ctrl),
        .stall      (stall),
        .flush      (flush),
        .id_valid   (id_valid),
        .id_out     (id_out)
    );

endmodule

//--- design/riscv_id_ctrl.sv
module riscv_id_ctrl (
    input  riscv_isa_pkg::inst_t     inst,
    output riscv_ctrl_pkg::id_ctrl_t ctrl
);
    import riscv_isa_pkg::*;
    import riscv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;          // funct7 bit 30.
    alu_op_t    alu_fn;
    id_ctrl_t   dec;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;
    assign alt    = funct7[5];

    // funct3 to alu op, shared by op and op_imm.
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101: begin
                if (alt) begin
                    alu_fn = ALU_SRA;
                end else begin
                    alu_fn = ALU_SRL;
                end
            end
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    // ====================
    // main decode
    // ====================
    always_comb begin
        dec          = '0;
        dec.alu_op   = ALU_ADD;
        dec.op_a_sel = OPA_RS1;
        dec.op_b_sel = OPB_IMM;
        dec.mem_size = funct3;
        case (opcode)
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.op_a_sel  = OPA_ZERO;
                dec.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                dec.op_a_sel  = OPA_PC;
                dec.reg_write = 1'b1;
            end
            OPC_JAL: begin
                dec.op_a_sel  = OPA_PC;
                dec.jump      = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_JALR: begin
                dec.jump      = 1'b1;
                dec.reg_write = 1'b1;
                dec.use_rs1   = 1'b1;
            end
            OPC_BRANCH: begin
                dec.alu_op   = ALU_SUB;             // compare rs1 with rs2.
                dec.op_b_sel = OPB_RS2;
                dec.branch   = 1'b1;
                dec.use_rs1  = 1'b1;
                dec.use_rs2  = 1'b1;
            end
            OPC_LOAD: begin
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.use_rs1   = 1'b1;
            end
            OPC_STORE: begin
                dec.mem_write = 1'b1;
                dec.use_rs1   = 1'b1;
                dec.use_rs2   = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.alu_op    = alu_fn;
                dec.reg_write = 1'b1;
                dec.use_rs1   = 1'b1;
            end
            OPC_OP: begin
                dec.alu_op = alu_fn;
                if (funct3 == 3'b000 && alt) begin
                    dec.alu_op = ALU_SUB;
                end
                dec.op_b_sel  = OPB_RS2;
                dec.reg_write = 1'b1;
                dec.use_rs1   = 1'b1;
                dec.use_rs2   = 1'b1;
                dec.illegal   = (funct7 != 7'h00 && funct7 != 7'h20) ||
                                (alt && funct3 != 3'b000 && funct3 != 3'b101);
            end
            OPC_FENCE,
            OPC_SYSTEM: begin
                // treated as no-ops.
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase

        if (dec.illegal) begin
            dec.reg_write = 1'b0;
            dec.mem_read  = 1'b0;
            dec.mem_write = 1'b0;
            dec.branch    = 1'b0;
            dec.jump      = 1'b0;
        end
    end

    assign ctrl = dec;

endmodule

//--- design/riscv_id_imm.sv
module riscv_id_imm (
    input  riscv_isa_pkg::inst_t inst,
    output riscv_isa_pkg::data_t imm
);
    import riscv_isa_pkg::*;

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;

    // ====================
    // per-format immediates
    // ====================
    assign imm_i = {{(DATA_WIDTH-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};

    assign imm_s = {{(DATA_WIDTH-12){inst.s.imm_11_5[6]}},
                    inst.s.imm_11_5,
                    inst.s.imm_4_0};

    assign imm_b = {{(DATA_WIDTH-13){inst.b.imm_12}},
                    inst.b.imm_12,
                    inst.b.imm_11,
                    inst.b.imm_10_5,
                    inst.b.imm_4_1,
                    1'b0};                          // halfword aligned.

    assign imm_u = {inst.u.imm_31_12, 12'b0};

    assign imm_j = {{(DATA_WIDTH-21){inst.j.imm_20}},
                    inst.j.imm_20,
                    inst.j.imm_19_12,
                    inst.j.imm_11,
                    inst.j.imm_10_1,
                    1'b0};

    // ====================
    // select by opcode
    // ====================
    always_comb begin
        case (inst.r.opcode)
            OPC_LUI,
            OPC_AUIPC:  imm = imm_u;
            OPC_JAL:    imm = imm_j;
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: imm = imm_i;
            OPC_BRANCH: imm = imm_b;
            OPC_STORE:  imm = imm_s;
            default:    imm = '0;                  // op, fence, system, unknown.
        endcase
    end

endmodule

//--- design/riscv_id_reg.sv
module riscv_id_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       inst_valid,
    input  riscv_isa_pkg::inst_t       inst,
    input  riscv_isa_pkg::data_t       pc,
    input  riscv_isa_pkg::data_t       imm,
    input  riscv_ctrl_pkg::id_ctrl_t   ctrl,
    input  logic                       stall,
    input  logic                       flush,
    output logic                       id_valid,
    output riscv_ctrl_pkg::id_bundle_t id_out
);
    import riscv_isa_pkg::*;
    import riscv_ctrl_pkg::*;

    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    id_bundle_t bundle;

    // unused register fields read as zero.
    assign rs1 = ctrl.use_rs1   ? inst.r.rs1 : '0;
    assign rs2 = ctrl.use_rs2   ? inst.r.rs2 : '0;
    assign rd  = ctrl.reg_write ? inst.r.rd  : '0;

    always_comb begin
        bundle.pc   = pc;
        bundle.imm  = imm;
        bundle.rs1  = rs1;
        bundle.rs2  = rs2;
        bundle.rd   = rd;
        bundle.ctrl = ctrl;
    end

    // ====================
    // pipeline register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else if (flush) begin
            id_valid <= 1'b0;                       // wins over stall.
        end else if (!stall) begin
            id_valid <= inst_valid;
            if (inst_valid) begin
                id_out <= bundle;
            end
        end
    end

endmodule

//--- design/riscv_isa_pkg.sv
package riscv_isa_pkg;

    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [4:0]            reg_addr_t;

    // ====================
    // opcodes
    // ====================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ====================
    // instruction formats
    // ====================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t     r;
        inst_i_t     i;
        inst_s_t     s;
        inst_b_t     b;
        inst_u_t     u;
        inst_j_t     j;
        logic [31:0] raw;
    } inst_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module riscv_id_tb -o riscv_id_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/riscv_id_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- src.f
design/riscv_isa_pkg.sv
design/riscv_ctrl_pkg.sv
design/riscv_id_imm.sv
design/riscv_id_ctrl.sv
design/riscv_id_reg.sv
design/riscv_id.sv
bench/riscv_id_tb.sv
